// ==== execSlice.f ====
source/execPkg.sv
source/regFile.sv
source/execUnit.sv
source/execSlice.sv
tb/execChecker.sv
tb/execSliceTb.sv

// ==== source/execPkg.sv ====
// Shared widths and ALU opcodes for the execution slice, referenced by package-scoped name
package execPkg;

	// Data path
	localparam int WORD_WIDTH = 32;

	// Register file geometry
	localparam int REG_COUNT = 8;
	localparam int REG_ADDR_WIDTH = $clog2(REG_COUNT);

	// ALU opcode field
	localparam int ALU_OP_WIDTH = 2;

	// A + B
	localparam logic [ALU_OP_WIDTH-1:0] OP_ADD = 2'd0;

	// B - A, operands reversed on purpose
	localparam logic [ALU_OP_WIDTH-1:0] OP_SUB = 2'd1;

	// A >> B, logical, zero once B reaches the word width
	localparam logic [ALU_OP_WIDTH-1:0] OP_SHR = 2'd2;

	// 0 - A
	localparam logic [ALU_OP_WIDTH-1:0] OP_NEG = 2'd3;

	// Most negative word, only the sign bit set
	localparam logic [WORD_WIDTH-1:0] SIGN_MIN = {1'b1, {(WORD_WIDTH-1){1'b0}}};

endpackage

// ==== source/execSlice.sv ====
// Top level of the execution slice, joining the register file and the ALU to the pins
`timescale 1ns/10ps

module execSlice
(
	input  logic                               clk,
	input  logic                               reset,

	// ALU writeback control
	input  logic                               aluWrite,
	input  logic [execPkg::REG_ADDR_WIDTH-1:0] aluDest,

	// External load
	input  logic                               loadWrite,
	input  logic [execPkg::REG_ADDR_WIDTH-1:0] loadDest,
	input  logic [execPkg::WORD_WIDTH-1:0]     loadData,

	// Read addresses
	input  logic [execPkg::REG_ADDR_WIDTH-1:0] srcA,
	input  logic [execPkg::REG_ADDR_WIDTH-1:0] srcB,
	input  logic [execPkg::REG_ADDR_WIDTH-1:0] srcC,
	input  logic [execPkg::REG_ADDR_WIDTH-1:0] srcD,

	// ALU control
	input  logic [execPkg::ALU_OP_WIDTH-1:0]   aluOp,
	input  logic                               flagWrite,

	// Read buses
	output logic [execPkg::WORD_WIDTH-1:0]     busA,
	output logic [execPkg::WORD_WIDTH-1:0]     busB,
	output logic [execPkg::WORD_WIDTH-1:0]     busC,
	output logic [execPkg::WORD_WIDTH-1:0]     busD,

	// ALU result and flags
	output logic [execPkg::WORD_WIDTH-1:0]     aluResult,
	output logic                               flagN,
	output logic                               flagZ,
	output logic                               flagC,
	output logic                               flagV
);

	// Buses A and B double as the ALU operands, result feeds write port 1
	regFile regFile_i
	(
		.clk       (clk),
		.reset     (reset),
		.aluWrite  (aluWrite),
		.aluDest   (aluDest),
		.aluResult (aluResult),
		.loadWrite (loadWrite),
		.loadDest  (loadDest),
		.loadData  (loadData),
		.srcA      (srcA),
		.srcB      (srcB),
		.srcC      (srcC),
		.srcD      (srcD),
		.busA      (busA),
		.busB      (busB),
		.busC      (busC),
		.busD      (busD)
	);

	execUnit execUnit_i
	(
		.clk       (clk),
		.reset     (reset),
		.operandA  (busA),
		.operandB  (busB),
		.aluOp     (aluOp),
		.flagWrite (flagWrite),
		.aluResult (aluResult),
		.flagN     (flagN),
		.flagZ     (flagZ),
		.flagC     (flagC),
		.flagV     (flagV)
	);

endmodule

// ==== source/execUnit.sv ====
// Four-operation ALU with N/Z/C/V generation and the enabled status flag register
`timescale 1ns/10ps

module execUnit
(
	input  logic                             clk,
	input  logic                             reset,

	// Operands from register file buses A and B
	input  logic [execPkg::WORD_WIDTH-1:0]   operandA,
	input  logic [execPkg::WORD_WIDTH-1:0]   operandB,

	// Control
	input  logic [execPkg::ALU_OP_WIDTH-1:0] aluOp,
	input  logic                             flagWrite,

	// Combinational result
	output logic [execPkg::WORD_WIDTH-1:0]   aluResult,

	// Registered status flags
	output logic                             flagN,
	output logic                             flagZ,
	output logic                             flagC,
	output logic                             flagV
);

	// Extra bit holds the add carry
	logic [execPkg::WORD_WIDTH:0]   sum;
	logic [execPkg::WORD_WIDTH-1:0] shiftOneLess;
	logic                           bigShift;

	logic nextN;
	logic nextZ;
	logic nextC;
	logic nextV;

	assign sum = {1'b0, operandA} + {1'b0, operandB};

	// Bit 0 of this is the last bit shifted out
	assign shiftOneLess = operandA >> (operandB - 1'b1);
	assign bigShift = operandB >= execPkg::WORD_WIDTH;

	always_comb
	begin
		aluResult = '0;
		nextC = 1'b0;
		nextV = 1'b0;
		case (aluOp)
			execPkg::OP_ADD:
			begin
				aluResult = sum[execPkg::WORD_WIDTH-1:0];
				nextC = sum[execPkg::WORD_WIDTH];
				nextV = (operandA[execPkg::WORD_WIDTH-1] == operandB[execPkg::WORD_WIDTH-1])
					&& (aluResult[execPkg::WORD_WIDTH-1] != operandA[execPkg::WORD_WIDTH-1]);
			end
			execPkg::OP_SUB:
			begin
				aluResult = operandB - operandA;
				nextC = operandA < operandB;
				nextV = (operandA[execPkg::WORD_WIDTH-1] != operandB[execPkg::WORD_WIDTH-1])
					&& (aluResult[execPkg::WORD_WIDTH-1] != operandB[execPkg::WORD_WIDTH-1]);
			end
			execPkg::OP_SHR:
			begin
				if (bigShift)
				begin
					aluResult = '0;
					nextC = operandA[execPkg::WORD_WIDTH-1];
				end
				else
				begin
					aluResult = operandA >> operandB;
					nextC = (operandB != '0) && shiftOneLess[0];
				end
			end
			execPkg::OP_NEG:
			begin
				aluResult = '0 - operandA;
				nextC = operandA != '0;
				nextV = operandA == execPkg::SIGN_MIN;
			end
			default:
			begin
				aluResult = '0;
			end
		endcase
	end

	assign nextN = aluResult[execPkg::WORD_WIDTH-1];
	assign nextZ = aluResult == '0;

	// Status flags load only when asked
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			flagN <= 1'b0;
			flagZ <= 1'b0;
			flagC <= 1'b0;
			flagV <= 1'b0;
		end
		else if (flagWrite)
		begin
			flagN <= nextN;
			flagZ <= nextZ;
			flagC <= nextC;
			flagV <= nextV;
		end
	end

	opKnown: assert property
	(
		@(posedge clk) disable iff (reset)
		flagWrite |-> !$isunknown(aluOp)
	)
	else
		$error("execUnit flag write with unknown opcode");

	// A shift never overflows
	shiftNoOverflow: assert property
	(
		@(posedge clk) disable iff (reset)
		(flagWrite && aluOp == execPkg::OP_SHR) |=> !flagV
	)
	else
		$error("execUnit flagV set after shift");

endmodule

// ==== source/regFile.sv ====
// Register file with ALU writeback and load write ports and four combinational read ports
`timescale 1ns/10ps

module regFile
(
	input  logic                               clk,
	input  logic                               reset,

	// Write port 1, ALU writeback
	input  logic                               aluWrite,
	input  logic [execPkg::REG_ADDR_WIDTH-1:0] aluDest,
	input  logic [execPkg::WORD_WIDTH-1:0]     aluResult,

	// Write port 2, external load
	input  logic                               loadWrite,
	input  logic [execPkg::REG_ADDR_WIDTH-1:0] loadDest,
	input  logic [execPkg::WORD_WIDTH-1:0]     loadData,

	// Read addresses
	input  logic [execPkg::REG_ADDR_WIDTH-1:0] srcA,
	input  logic [execPkg::REG_ADDR_WIDTH-1:0] srcB,
	input  logic [execPkg::REG_ADDR_WIDTH-1:0] srcC,
	input  logic [execPkg::REG_ADDR_WIDTH-1:0] srcD,

	// Read data
	output logic [execPkg::WORD_WIDTH-1:0]     busA,
	output logic [execPkg::WORD_WIDTH-1:0]     busB,
	output logic [execPkg::WORD_WIDTH-1:0]     busC,
	output logic [execPkg::WORD_WIDTH-1:0]     busD
);

	logic [execPkg::WORD_WIDTH-1:0] regs [execPkg::REG_COUNT];

	// Load port is written second so it wins when both target one register
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < execPkg::REG_COUNT; i++)
			begin
				regs[i] <= '0;
			end
		end
		else
		begin
			if (aluWrite)
			begin
				regs[aluDest] <= aluResult;
			end
			if (loadWrite)
			begin
				regs[loadDest] <= loadData;
			end
		end
	end

	// Independent read selects, no latency
	assign busA = regs[srcA];
	assign busB = regs[srcB];
	assign busC = regs[srcC];
	assign busD = regs[srcD];

	// A write with an undefined destination would corrupt an unknown register
	destKnown: assert property
	(
		@(posedge clk) disable iff (reset)
		(aluWrite |-> !$isunknown(aluDest)) and (loadWrite |-> !$isunknown(loadDest))
	)
	else
		$error("regFile write with unknown destination address");

	// Load data must survive a collision with the ALU port
	loadLands: assert property
	(
		@(posedge clk) disable iff (reset)
		loadWrite |=> regs[$past(loadDest)] == $past(loadData)
	)
	else
		$error("regFile load port value missing after write");

endmodule

// ==== tb/execChecker.sv ====
// Testbench checker with a shadow model of the registers and flags, compared before each edge
`timescale 1ns/10ps

module execChecker
(
	input  logic                               clk,
	input  logic                               reset,
	input  logic                               aluWrite,
	input  logic [execPkg::REG_ADDR_WIDTH-1:0] aluDest,
	input  logic                               loadWrite,
	input  logic [execPkg::REG_ADDR_WIDTH-1:0] loadDest,
	input  logic [execPkg::WORD_WIDTH-1:0]     loadData,
	input  logic [execPkg::REG_ADDR_WIDTH-1:0] srcA,
	input  logic [execPkg::REG_ADDR_WIDTH-1:0] srcB,
	input  logic [execPkg::REG_ADDR_WIDTH-1:0] srcC,
	input  logic [execPkg::REG_ADDR_WIDTH-1:0] srcD,
	input  logic [execPkg::ALU_OP_WIDTH-1:0]   aluOp,
	input  logic                               flagWrite,
	input  logic [execPkg::WORD_WIDTH-1:0]     busA,
	input  logic [execPkg::WORD_WIDTH-1:0]     busB,
	input  logic [execPkg::WORD_WIDTH-1:0]     busC,
	input  logic [execPkg::WORD_WIDTH-1:0]     busD,
	input  logic [execPkg::WORD_WIDTH-1:0]     aluResult,
	input  logic                               flagN,
	input  logic                               flagZ,
	input  logic                               flagC,
	input  logic                               flagV,

	// Hand-worked result from the stimulus table
	input  logic [execPkg::WORD_WIDTH-1:0]     expResult,
	input  logic                               expValid,

	output int                                 errors,
	output int                                 checks
);

	localparam int W = execPkg::WORD_WIDTH;

	logic [W-1:0] shadowRegs [execPkg::REG_COUNT];
	logic [W-1:0] nextRegs [execPkg::REG_COUNT];

	// N, Z, C, V from the top bit down
	logic [3:0]   shadowFlags;
	logic [3:0]   nextFlags;
	logic [W+3:0] model;

	int errorCount = 0;
	int checkCount = 0;

	assign errors = errorCount;
	assign checks = checkCount;

	// Flags above the result word
	function automatic logic [W+3:0] modelAlu(input logic [1:0] op, input logic [W-1:0] a,
		input logic [W-1:0] b);
		logic [W-1:0] r;
		logic         c;
		logic         v;
		c = 1'b0;
		v = 1'b0;
		if (op == execPkg::OP_ADD)
		begin
			{c, r} = {1'b0, a} + {1'b0, b};
			v = (a[W-1] == b[W-1]) && (r[W-1] != a[W-1]);
		end
		else if (op == execPkg::OP_SUB)
		begin
			r = b - a;
			c = a < b;
			v = (a[W-1] != b[W-1]) && (r[W-1] != b[W-1]);
		end
		else if (op == execPkg::OP_SHR)
		begin
			if (b >= W)
			begin
				r = '0;
				c = a[W-1];
			end
			else
			begin
				r = a >> b[4:0];
				c = (b == 0) ? 1'b0 : a[b[4:0] - 5'd1];
			end
		end
		else
		begin
			r = '0 - a;
			c = a != '0;
			v = a == execPkg::SIGN_MIN;
		end
		return {r[W-1], r == '0, c, v, r};
	endfunction

	task automatic compare(input string name, input logic [W-1:0] expected,
		input logic [W-1:0] actual);
		checkCount++;
		if (actual !== expected)
		begin
			$display("Fail at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
			errorCount++;
		end
	endtask

	// Mid-cycle, all inputs and outputs have settled
	always @(negedge clk)
	begin
		model = modelAlu(aluOp, shadowRegs[srcA], shadowRegs[srcB]);
		if (!reset)
		begin
			compare("busA", shadowRegs[srcA], busA);
			compare("busB", shadowRegs[srcB], busB);
			compare("busC", shadowRegs[srcC], busC);
			compare("busD", shadowRegs[srcD], busD);
			compare("aluResult", model[W-1:0], aluResult);
			compare("flagN", shadowFlags[3], flagN);
			compare("flagZ", shadowFlags[2], flagZ);
			compare("flagC", shadowFlags[1], flagC);
			compare("flagV", shadowFlags[0], flagV);
			if (expValid)
			begin
				compare("aluResult against table", expResult, aluResult);
			end
		end
		for (int i = 0; i < execPkg::REG_COUNT; i++)
		begin
			nextRegs[i] = reset ? '0 : shadowRegs[i];
		end
		nextFlags = reset ? 4'b0 : shadowFlags;
		if (!reset)
		begin
			if (aluWrite)
			begin
				nextRegs[aluDest] = model[W-1:0];
			end
			// Load after ALU so it wins a collision
			if (loadWrite)
			begin
				nextRegs[loadDest] = loadData;
			end
			if (flagWrite)
			begin
				nextFlags = model[W+3:W];
			end
		end
	end

	always @(posedge clk)
	begin
		for (int i = 0; i < execPkg::REG_COUNT; i++)
		begin
			shadowRegs[i] <= nextRegs[i];
		end
		shadowFlags <= nextFlags;
	end

endmodule

// ==== tb/execSliceTb.sv ====
// Testbench top for the execution slice, runs a directed table then a random phase
`timescale 1ns/10ps

module execSliceTb;

	localparam int ROWS = 26;
	localparam int RANDOM_CYCLES = 200;
	localparam int PERIOD = 40;
	localparam int W = execPkg::WORD_WIDTH;
	localparam int RA = execPkg::REG_ADDR_WIDTH;

	typedef struct packed
	{
		logic                            aluWrite;
		logic [RA-1:0]                   aluDest;
		logic                            loadWrite;
		logic [RA-1:0]                   loadDest;
		logic [W-1:0]                    loadData;
		logic [RA-1:0]                   srcA;
		logic [RA-1:0]                   srcB;
		logic [RA-1:0]                   srcC;
		logic [RA-1:0]                   srcD;
		logic [execPkg::ALU_OP_WIDTH-1:0] aluOp;
		logic                            flagWrite;
		logic [W-1:0]                    expResult;
		logic                            expValid;
	} stepT;

	logic clk;
	logic reset;
	logic aluWrite;
	logic [RA-1:0] aluDest;
	logic loadWrite;
	logic [RA-1:0] loadDest;
	logic [W-1:0] loadData;
	logic [RA-1:0] srcA;
	logic [RA-1:0] srcB;
	logic [RA-1:0] srcC;
	logic [RA-1:0] srcD;
	logic [execPkg::ALU_OP_WIDTH-1:0] aluOp;
	logic flagWrite;
	logic [W-1:0] expResult;
	logic expValid;

	logic [W-1:0] busA;
	logic [W-1:0] busB;
	logic [W-1:0] busC;
	logic [W-1:0] busD;
	logic [W-1:0] aluResult;
	logic flagN;
	logic flagZ;
	logic flagC;
	logic flagV;

	int errors;
	int checks;
	int rowCount = 0;
	logic [31:0] lcgState;
	stepT steps [ROWS];

	execSlice dut_i
	(
		.clk(clk), .reset(reset), .aluWrite(aluWrite), .aluDest(aluDest),
		.loadWrite(loadWrite), .loadDest(loadDest), .loadData(loadData),
		.srcA(srcA), .srcB(srcB), .srcC(srcC), .srcD(srcD),
		.aluOp(aluOp), .flagWrite(flagWrite),
		.busA(busA), .busB(busB), .busC(busC), .busD(busD),
		.aluResult(aluResult), .flagN(flagN), .flagZ(flagZ), .flagC(flagC), .flagV(flagV)
	);

	execChecker checker_i
	(
		.clk(clk), .reset(reset), .aluWrite(aluWrite), .aluDest(aluDest),
		.loadWrite(loadWrite), .loadDest(loadDest), .loadData(loadData),
		.srcA(srcA), .srcB(srcB), .srcC(srcC), .srcD(srcD),
		.aluOp(aluOp), .flagWrite(flagWrite),
		.busA(busA), .busB(busB), .busC(busC), .busD(busD),
		.aluResult(aluResult), .flagN(flagN), .flagZ(flagZ), .flagC(flagC), .flagV(flagV),
		.expResult(expResult), .expValid(expValid), .errors(errors), .checks(checks)
	);

	initial
	begin
		clk = 1'b0;
		forever
		begin
			#(PERIOD / 2) clk = ~clk;
		end
	end

	function automatic logic [31:0] lcgNext(input logic [31:0] state);
		return state * 32'd1103515245 + 32'd12345;
	endfunction

	task automatic addRow(input logic aw, input logic [RA-1:0] ad, input logic lw,
		input logic [RA-1:0] ld, input logic [W-1:0] data, input logic [RA-1:0] sa,
		input logic [RA-1:0] sb, input logic [RA-1:0] sc, input logic [RA-1:0] sd,
		input logic [1:0] op, input logic fw, input logic [W-1:0] exp, input logic ev);
		steps[rowCount] = {aw, ad, lw, ld, data, sa, sb, sc, sd, op, fw, exp, ev};
		rowCount++;
	endtask

	task automatic applyRow(input stepT s);
		aluWrite <= s.aluWrite;
		aluDest <= s.aluDest;
		loadWrite <= s.loadWrite;
		loadDest <= s.loadDest;
		loadData <= s.loadData;
		srcA <= s.srcA;
		srcB <= s.srcB;
		srcC <= s.srcC;
		srcD <= s.srcD;
		aluOp <= s.aluOp;
		flagWrite <= s.flagWrite;
		expResult <= s.expResult;
		expValid <= s.expValid;
	endtask

	task automatic driveRandom();
		logic [31:0] ctrl;
		logic [31:0] data;
		lcgState = lcgNext(lcgState);
		ctrl = lcgState;
		lcgState = lcgNext(lcgState);
		data = lcgState;
		aluWrite <= ctrl[31];
		loadWrite <= ctrl[30];
		aluDest <= ctrl[29:27];
		loadDest <= ctrl[26:24];
		srcA <= ctrl[23:21];
		srcB <= ctrl[20:18];
		srcC <= ctrl[17:15];
		srcD <= ctrl[14:12];
		aluOp <= ctrl[11:10];
		flagWrite <= ctrl[9];
		// Small values now and then so shifts land inside the word
		loadData <= ctrl[8] ? (data & 32'h3F) : data;
		expResult <= '0;
		expValid <= 1'b0;
	endtask

	// Watchdog
	initial
	begin
		#((3 + ROWS + RANDOM_CYCLES + 10) * PERIOD);
		$display("Run timed out before the stimulus finished");
		$display("RESULT: FAIL");
		$finish;
	end

	initial
	begin
		reset = 1'b1;
		applyRow('0);
		lcgState = 32'd93;

		// Reset state, then a load into every register
		addRow(0, 0, 0, 0, 32'h0, 0, 0, 0, 0, execPkg::OP_ADD, 0, 32'h0, 1);
		addRow(0, 0, 1, 0, 32'h0000_0000, 0, 0, 0, 0, execPkg::OP_ADD, 0, 32'h0, 0);
		addRow(0, 0, 1, 1, 32'hFFFF_FFFF, 0, 0, 0, 0, execPkg::OP_ADD, 0, 32'h0, 0);
		addRow(0, 0, 1, 2, 32'h0000_0001, 0, 0, 0, 0, execPkg::OP_ADD, 0, 32'h0, 0);
		addRow(0, 0, 1, 3, 32'h7FFF_FFFF, 0, 0, 0, 0, execPkg::OP_ADD, 0, 32'h0, 0);
		addRow(0, 0, 1, 4, 32'h8000_0000, 0, 0, 0, 0, execPkg::OP_ADD, 0, 32'h0, 0);
		addRow(0, 0, 1, 5, 32'h0000_0028, 0, 0, 0, 0, execPkg::OP_ADD, 0, 32'h0, 0);
		addRow(0, 0, 1, 6, 32'h0000_001F, 0, 0, 0, 0, execPkg::OP_ADD, 0, 32'h0, 0);
		addRow(0, 0, 1, 7, 32'h1234_5678, 0, 0, 0, 0, execPkg::OP_ADD, 0, 32'h0, 0);
		// Read back, one register on two ports
		addRow(0, 0, 0, 0, 32'h0, 1, 2, 3, 3, execPkg::OP_ADD, 0, 32'h0, 1);
		addRow(0, 0, 0, 0, 32'h0, 4, 5, 6, 7, execPkg::OP_ADD, 0, 32'h8000_0028, 1);
		addRow(0, 0, 0, 0, 32'h0, 0, 0, 0, 0, execPkg::OP_ADD, 0, 32'h0, 1);
		// ALU edge cases with flag writes
		addRow(0, 0, 0, 0, 32'h0, 1, 2, 0, 0, execPkg::OP_ADD, 1, 32'h0, 1);
		addRow(0, 0, 0, 0, 32'h0, 3, 2, 0, 0, execPkg::OP_ADD, 1, 32'h8000_0000, 1);
		addRow(0, 0, 0, 0, 32'h0, 2, 4, 0, 0, execPkg::OP_SUB, 1, 32'h7FFF_FFFF, 1);
		addRow(0, 0, 0, 0, 32'h0, 2, 7, 0, 0, execPkg::OP_SUB, 1, 32'h1234_5677, 1);
		addRow(0, 0, 0, 0, 32'h0, 7, 0, 0, 0, execPkg::OP_SHR, 1, 32'h1234_5678, 1);
		addRow(0, 0, 0, 0, 32'h0, 1, 6, 0, 0, execPkg::OP_SHR, 1, 32'h0000_0001, 1);
		addRow(0, 0, 0, 0, 32'h0, 4, 5, 0, 0, execPkg::OP_SHR, 1, 32'h0, 1);
		addRow(0, 0, 0, 0, 32'h0, 0, 0, 0, 0, execPkg::OP_NEG, 1, 32'h0, 1);
		addRow(0, 0, 0, 0, 32'h0, 4, 0, 0, 0, execPkg::OP_NEG, 1, 32'h8000_0000, 1);
		// Writeback into r3 with flags held
		addRow(1, 3, 0, 0, 32'h0, 7, 2, 0, 0, execPkg::OP_ADD, 0, 32'h1234_5679, 1);
		addRow(0, 0, 0, 0, 32'h0, 3, 3, 3, 3, execPkg::OP_SHR, 0, 32'h0, 1);
		// Same register on both ports, then different registers
		addRow(1, 5, 1, 5, 32'hDEAD_BEEF, 1, 2, 0, 0, execPkg::OP_ADD, 1, 32'h0, 1);
		addRow(1, 6, 1, 7, 32'hCAFE_F00D, 2, 2, 0, 0, execPkg::OP_ADD, 0, 32'h2, 1);
		addRow(0, 0, 0, 0, 32'h0, 5, 6, 7, 0, execPkg::OP_NEG, 0, 32'h2152_4111, 1);

		repeat (3) @(posedge clk);
		reset <= 1'b0;
		for (int i = 0; i < ROWS; i++)
		begin
			@(posedge clk);
			applyRow(steps[i]);
		end
		for (int i = 0; i < RANDOM_CYCLES; i++)
		begin
			@(posedge clk);
			driveRandom();
		end
		@(posedge clk);
		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule
